// File: source/inv_pkg.sv
// shared types for the streaming modular inverter
// holds the binary gcd FSM states and the request status codes
// reported on the error strobe

package inv_pkg;

  // ====================================================================
  // inverter FSM
  // ====================================================================
  typedef enum logic [2:0] {
    IDLE,       // waiting for an operand from the FIFO
    U_STATE,    // halving u until it is odd
    V_STATE,    // halving v until it is odd
    UPDATE,     // subtract the smaller of u and v from the larger
    FINISHED    // result held until the output handshake
  } inv_state_e;

  // ====================================================================
  // request outcome
  // ====================================================================
  typedef enum logic [1:0] {
    ST_OK,      // operand reduced and queued for inversion
    ST_ZERO,    // operand is zero mod P so it has no inverse
    ST_RANGE    // operand is 2P or more and cannot be reduced in one step
  } req_status_e;

endpackage

// File: source/mod_reduce.sv
`timescale 1ns/1ns
// input reduction stage of the inverter
// takes one request at a time and brings it into 0..P-1 with a single
// conditional subtraction, then hands it on or flags it on the error strobe

module mod_reduce #(
  parameter int              BITS = 16,
  parameter logic [BITS-1:0] P    = 'hfff1
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic [BITS-1:0]      i_dat,
  input  logic                 i_val,
  input  logic                 i_rdy,
  output logic                 o_rdy,
  output logic [BITS-1:0]      o_dat,
  output logic                 o_val,
  output logic                 o_err,
  output inv_pkg::req_status_e o_err_code
);
  import inv_pkg::*;

  logic            live;    // high from the first edge after reset release
  logic            take;    // request accepted on this edge
  logic            ge_p;    // operand is P or above
  logic            over;    // operand is 2P or above
  logic            zero;    // reduced value has no inverse
  logic [BITS-1:0] red;     // operand after the conditional subtraction
  req_status_e     status;  // outcome of the operand on the input port

  // ====================================================================
  // classification of the incoming operand
  // ====================================================================
  assign ge_p  = (i_dat >= P);
  assign over  = ({1'b0, i_dat} >= {P, 1'b0});  // one extra bit to hold 2P
  assign red   = ge_p ? (i_dat - P) : i_dat;
  assign zero  = (red == '0);                    // covers both 0 and P
  assign take  = i_val && o_rdy;
  assign o_rdy = live && (!o_val || i_rdy);      // empty, or the held item leaves now

  always_comb begin
    if (over) begin
      status = ST_RANGE;
    end else if (zero) begin
      status = ST_ZERO;
    end else begin
      status = ST_OK;
    end
  end

  // ====================================================================
  // stage control
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      live  <= 1'b0;
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else begin
      live  <= 1'b1;
      o_err <= 1'b0;                             // strobe lasts a single cycle
      if (o_val && i_rdy) begin
        o_val <= 1'b0;                           // FIFO took the held operand
      end
      if (take) begin
        o_err <= (status != ST_OK);              // a reject frees the stage at once
        o_val <= (status == ST_OK);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (take) begin
      o_dat      <= red;                         // only meaningful when o_val rises
      o_err_code <= status;
    end
  end

  // a rejected operand must never also reach the FIFO
  a_val_err_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_val && o_err));

endmodule

// File: source/inv_fifo.sv
`timescale 1ns/1ns
// operand buffer between the reducer and the inverter
// synchronous first-word-fall-through FIFO, the head word is always on o_dat

module inv_fifo #(
  parameter int BITS       = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [BITS-1:0] i_dat,
  input  logic            i_val,
  input  logic            i_rdy,
  output logic            o_rdy,
  output logic [BITS-1:0] o_dat,
  output logic            o_val
);

  localparam int          AW   = $clog2(FIFO_DEPTH);   // pointer width
  localparam logic [AW:0] FULL = (AW+1)'(FIFO_DEPTH);  // count value when full

  logic [BITS-1:0] mem [FIFO_DEPTH];  // operand storage
  logic [AW-1:0]   wr_ptr;            // next slot to write, wraps at the depth
  logic [AW-1:0]   rd_ptr;            // head slot
  logic [AW:0]     count;             // words currently held
  logic            push;
  logic            pop;

  // ====================================================================
  // handshake and head word
  // ====================================================================
  assign o_rdy = (count != FULL);     // not full
  assign o_val = (count != '0);       // not empty
  assign o_dat = mem[rd_ptr];         // fall through, no read latency
  assign push  = i_val && o_rdy;
  assign pop   = o_val && i_rdy;

  // ====================================================================
  // pointers and occupancy
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;      // power of two depth so it wraps by itself
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_dat;
    end
  end

  a_count_max: assert property (@(posedge i_clk) disable iff (i_rst)
    count <= FULL);

  // the head may only advance when a word was there to take
  a_no_empty_pop: assert property (@(posedge i_clk) disable iff (i_rst)
    (rd_ptr != $past(rd_ptr)) |-> ($past(count) != '0));

endmodule

// File: source/bin_inv.sv
`timescale 1ns/1ns
// binary extended gcd inverter mod P
// computes one inverse at a time, latency depends on the operand
// u and v start at the operand and at P, x1 and x2 are their cofactors

module bin_inv #(
  parameter int              BITS = 16,
  parameter logic [BITS-1:0] P    = 'hfff1
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [BITS-1:0] i_dat,
  input  logic            i_val,
  input  logic            i_rdy,
  output logic            o_rdy,
  output logic [BITS-1:0] o_dat,
  output logic            o_val
);
  import inv_pkg::*;

  localparam logic [BITS:0] ONE = 1;

  inv_state_e    state;
  logic [BITS:0] u;         // starts at the operand
  logic [BITS:0] v;         // starts at P
  logic [BITS:0] x1;        // cofactor of u, kept below P
  logic [BITS:0] x2;        // cofactor of v, kept below P
  logic [BITS:0] p_ext;     // P with one bit of headroom
  logic [BITS:0] u_half;
  logic [BITS:0] v_half;
  logic [BITS:0] x1_half;   // x1 / 2 mod P
  logic [BITS:0] x2_half;   // x2 / 2 mod P
  logic [BITS:0] u_sub;     // u - v
  logic [BITS:0] v_sub;     // v - u
  logic [BITS:0] x1_sub;    // x1 - x2 mod P
  logic [BITS:0] x2_sub;    // x2 - x1 mod P
  logic          take;

  // ====================================================================
  // datapath arithmetic
  // ====================================================================
  assign p_ext   = {1'b0, P};
  assign u_half  = u >> 1;
  assign v_half  = v >> 1;
  // an odd cofactor gets P added first so the halving stays exact mod P
  assign x1_half = x1[0] ? ((x1 + p_ext) >> 1) : (x1 >> 1);
  assign x2_half = x2[0] ? ((x2 + p_ext) >> 1) : (x2 >> 1);
  assign u_sub   = u - v;
  assign v_sub   = v - u;
  assign x1_sub  = x1 + ((x1 >= x2) ? '0 : p_ext) - x2;  // stays in 0..P-1
  assign x2_sub  = x2 + ((x2 >= x1) ? '0 : p_ext) - x1;
  assign take    = o_rdy && i_val;

  // ====================================================================
  // control FSM
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
      o_rdy <= 1'b0;
      o_val <= 1'b0;
    end else begin
      o_rdy <= 1'b0;                        // only IDLE raises it
      case (state)
        IDLE: begin
          o_rdy <= 1'b1;
          if (take) begin
            o_rdy <= 1'b0;
            state <= U_STATE;
          end
        end
        U_STATE: begin
          if (u[0] || u_half[0]) begin      // u odd now or after this halving
            state <= V_STATE;
          end
        end
        V_STATE: begin
          if (v[0] || v_half[0]) begin
            state <= UPDATE;
          end
        end
        UPDATE: begin
          if (u >= v) begin
            if (u_sub == ONE || v == ONE) begin
              state <= FINISHED;
            end else begin
              state <= U_STATE;
            end
          end else begin
            if (v_sub == ONE || u == ONE) begin
              state <= FINISHED;
            end else begin
              state <= U_STATE;
            end
          end
        end
        FINISHED: begin
          if (!o_val) begin
            o_val <= 1'b1;                  // result registered on this edge
          end else if (i_rdy) begin
            o_val <= 1'b0;
            o_rdy <= 1'b1;                  // ready again right after the transfer
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ====================================================================
  // working registers
  // ====================================================================
  always_ff @(posedge i_clk) begin
    case (state)
      IDLE: begin
        if (take) begin
          u  <= {1'b0, i_dat};
          v  <= p_ext;
          x1 <= ONE;
          x2 <= '0;
        end
      end
      U_STATE: begin
        if (!u[0]) begin
          u  <= u_half;
          x1 <= x1_half;
        end
      end
      V_STATE: begin
        if (!v[0]) begin
          v  <= v_half;
          x2 <= x2_half;
        end
      end
      UPDATE: begin
        if (u >= v) begin
          u  <= u_sub;
          x1 <= x1_sub;
        end else begin
          v  <= v_sub;
          x2 <= x2_sub;
        end
      end
      FINISHED: begin
        if (!o_val) begin
          o_dat <= (u == ONE) ? x1[BITS-1:0] : x2[BITS-1:0];  // cofactor of the 1
        end
      end
      default: ;
    endcase
  end

  // the reducer must have filtered zero, otherwise u never becomes odd
  a_nonzero_in: assert property (@(posedge i_clk) disable iff (i_rst)
    take |-> (i_dat != '0));

  a_hold_result: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_dat)));

endmodule

// File: source/inv_unit.sv
`timescale 1ns/1ns
// streaming modular inverter top level
// reducer, operand FIFO and binary gcd inverter in a chain, results
// leave in request order and rejected requests raise the error strobe

module inv_unit #(
  parameter int              BITS       = 16,
  parameter logic [BITS-1:0] P          = 'hfff1,
  parameter int              FIFO_DEPTH = 4
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic [BITS-1:0]      i_dat,
  input  logic                 i_val,
  input  logic                 i_rdy,
  output logic                 o_rdy,
  output logic [BITS-1:0]      o_dat,
  output logic                 o_val,
  output logic                 o_err,
  output inv_pkg::req_status_e o_err_code
);

  logic [BITS-1:0] red_dat;  // reduced operand into the FIFO
  logic            red_val;
  logic            red_rdy;  // FIFO not full
  logic [BITS-1:0] q_dat;    // head of the FIFO
  logic            q_val;    // FIFO not empty
  logic            q_rdy;    // inverter idle

  // ====================================================================
  // pipeline
  // ====================================================================
  mod_reduce #(.BITS(BITS), .P(P)) u_mod_reduce (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_dat      (i_dat),
    .i_val      (i_val),
    .i_rdy      (red_rdy),
    .o_rdy      (o_rdy),
    .o_dat      (red_dat),
    .o_val      (red_val),
    .o_err      (o_err),
    .o_err_code (o_err_code)
  );

  inv_fifo #(.BITS(BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_inv_fifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (red_dat),
    .i_val (red_val),
    .i_rdy (q_rdy),
    .o_rdy (red_rdy),
    .o_dat (q_dat),
    .o_val (q_val)
  );

  bin_inv #(.BITS(BITS), .P(P)) u_bin_inv (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (q_dat),
    .i_val (q_val),
    .i_rdy (i_rdy),
    .o_rdy (q_rdy),
    .o_dat (o_dat),
    .o_val (o_val)
  );

endmodule

// File: dv/inv_unit_tb.sv
`timescale 1ns/1ns
// testbench for the streaming modular inverter
// replays operands from the data file, checks inverses in request order
// and the error strobes, with random back-pressure on the result port

module inv_unit_tb;
  import inv_pkg::*;

  localparam int              BITS       = 16;
  localparam logic [BITS-1:0] P          = 16'hfff1;
  localparam int              FIFO_DEPTH = 4;
  localparam int              NUM_VEC    = 15;                         // requests in the data file
  localparam int              TIMEOUT    = NUM_VEC * (4 * BITS + 20);  // cycles after reset

  logic            clk;
  logic            rst;
  logic [BITS-1:0] in_dat;
  logic            in_val;
  logic            in_rdy;                  // request port ready from the DUT
  logic [BITS-1:0] res_dat;
  logic            res_val;
  logic            res_rdy;                 // random back-pressure on the result port
  logic            err;
  req_status_e     err_code;

  logic [BITS-1:0] file_mem [3*NUM_VEC];    // three hex words per line, read flat
  logic [BITS-1:0] op_arr   [NUM_VEC];
  logic [BITS-1:0] st_arr   [NUM_VEC];
  logic [BITS-1:0] inv_arr  [NUM_VEC];
  int              res_q [$];               // indices of requests still owed a result
  int              err_q [$];               // indices of requests still owed an error strobe
  int              err_cnt;
  int              done_cnt;                // requests whose result or strobe was checked
  integer          seed;

  inv_unit #(.BITS(BITS), .P(P), .FIFO_DEPTH(FIFO_DEPTH)) u_inv_unit (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_dat      (in_dat),
    .i_val      (in_val),
    .i_rdy      (res_rdy),
    .o_rdy      (in_rdy),
    .o_dat      (res_dat),
    .o_val      (res_val),
    .o_err      (err),
    .o_err_code (err_code)
  );

  always #4 clk = ~clk;                     // 8 ns period

  always @(posedge clk) begin
    #1;
    res_rdy = (($unsigned($random(seed)) % 3) != 0);  // low about one cycle in three
  end

  task automatic check_val(input logic [BITS-1:0] got, input logic [BITS-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // ====================================================================
  // reset, file load and request driver
  // ====================================================================
  initial begin : main
    int errs_before;
    clk      = 1'b0;
    rst      = 1'b1;
    in_dat   = '0;
    in_val   = 1'b0;
    res_rdy  = 1'b0;
    seed     = 32'h9709_88ec;
    err_cnt  = 0;
    done_cnt = 0;
    $readmemh("dv/inv_unit_input.txt", file_mem);
    for (int i = 0; i < NUM_VEC; i++) begin
      op_arr[i]  = file_mem[3*i];
      st_arr[i]  = file_mem[3*i+1];
      inv_arr[i] = file_mem[3*i+2];
    end
    repeat (10) @(posedge clk);
    errs_before = err_cnt;
    check_val(BITS'({in_rdy, res_val, err}), '0, "ready, valid or error high in reset");
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_val(BITS'(in_rdy), BITS'(1), "o_rdy low on the first cycle after reset");
    $display("test reset: outputs in and after reset %s",
             (err_cnt == errs_before) ? "pass" : "FAIL");
    // with the top bit of P set no 16 bit operand reaches 2P, so no range rejects here
    for (int i = 0; i < NUM_VEC; i++) begin
      in_dat = op_arr[i];
      in_val = 1'b1;
      @(posedge clk);
      while (!in_rdy) @(posedge clk);       // held until the reducer takes it
      if (st_arr[i] == BITS'(ST_OK)) begin
        res_q.push_back(i);
      end else begin
        err_q.push_back(i);                 // rejected, only a strobe comes back
      end
      #1;
    end
    in_val = 1'b0;
    while (done_cnt < NUM_VEC) @(posedge clk);
    repeat (20) @(posedge clk);             // room for a stray result or strobe to show
    $display("checked %0d of %0d requests, %0d errors", done_cnt, NUM_VEC, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // ====================================================================
  // result monitor
  // ====================================================================
  initial begin : result_monitor
    int              idx;
    int              errs_before;
    logic            stalled;               // result was offered but not taken last edge
    logic [BITS-1:0] held;
    logic [BITS-1:0] prod;
    stalled = 1'b0;
    held    = '0;
    forever begin
      @(posedge clk);
      if (stalled) begin
        check_val(BITS'(res_val), BITS'(1), "o_val dropped while stalled");
        check_val(res_dat, held, "o_dat changed while stalled");
      end
      stalled = !rst && res_val && !res_rdy;
      held    = res_dat;
      if (!rst && res_val && res_rdy) begin
        if (res_q.size() == 0) begin
          $display("unexpected result %h at %0t ns with no request pending", res_dat, $time);
          err_cnt++;
        end else begin
          idx         = res_q.pop_front();
          errs_before = err_cnt;
          prod        = BITS'((32'(op_arr[idx]) * 32'(res_dat)) % 32'(P));  // must be 1
          check_val(res_dat, inv_arr[idx], "inverse");
          check_val(prod, BITS'(1), "operand times result mod P");
          $display("test %0d: operand %h result %h %s", idx, op_arr[idx], res_dat,
                   (err_cnt == errs_before) ? "pass" : "FAIL");
          done_cnt++;
        end
      end
    end
  end

  // ====================================================================
  // error strobe monitor and watchdog
  // ====================================================================
  initial begin : error_monitor
    int idx;
    int errs_before;
    forever begin
      @(posedge clk);
      if (!rst && err) begin
        if (err_q.size() == 0) begin
          $display("unexpected error strobe with code %0d at %0t ns", err_code, $time);
          err_cnt++;
        end else begin
          idx         = err_q.pop_front();
          errs_before = err_cnt;
          check_val(BITS'(err_code), st_arr[idx], "error code");
          $display("test %0d: operand %h rejected with code %0d %s", idx, op_arr[idx],
                   err_code, (err_cnt == errs_before) ? "pass" : "FAIL");
          done_cnt++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (10 + TIMEOUT) @(posedge clk);
    $display("run timed out with %0d of %0d requests finished", done_cnt, NUM_VEC);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: dv/inv_unit_input.txt
// columns: operand, expected status, expected inverse, all hex
// status 0 = ok, 1 = zero, 2 = range; inverse is 0 for a rejected operand
0001 0 0001
fff0 0 fff0
0002 0 7ff9
0004 0 bff5
0010 0 eff2
0100 0 eef2
8000 0 ddd1
0000 1 0000
0003 0 aaa1
fff1 1 0000
fff2 0 0001
fff3 0 7ff9
ffff 0 eda9
0005 0 ccc1
0007 0 db61

// File: src.f
source/inv_pkg.sv
source/mod_reduce.sv
source/inv_fifo.sv
source/bin_inv.sv
source/inv_unit.sv
dv/inv_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the inverter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module inv_unit_tb

out="$(./obj_dir/Vinv_unit_tb)"
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
